//--- hw/eval_settings.svh
`ifndef EVAL_SETTINGS_SVH
`define EVAL_SETTINGS_SVH

// Score widths
`define EVAL_WIDTH 16         // Final blended score
`define SUM_WIDTH 24          // Middlegame and endgame partial sums

// Phase taper
`define PHASE_MAX 62          // Cap on the occupied-square count
`define RECIP_SHIFT 20        // Scale exponent of the reciprocal
`define RECIP_62 16912        // floor(2^20 / 62)

// Latencies in clock cycles
`define BLEND_LATENCY 5       // Depth of the blend pipeline
`define EVAL_LATENCY 2        // Start to done in each evaluator

`endif

//--- hw/chess_pkg.sv
package chess_pkg;

   // Bit 3 set means a black piece, bits 2:0 give the piece kind
   typedef enum logic [3:0]
   {
      EMPTY    = 4'd0,
      W_PAWN   = 4'd1,
      W_KNIGHT = 4'd2,
      W_BISHOP = 4'd3,
      W_ROOK   = 4'd4,
      W_QUEEN  = 4'd5,
      W_KING   = 4'd6,
      B_PAWN   = 4'd9,
      B_KNIGHT = 4'd10,
      B_BISHOP = 4'd11,
      B_ROOK   = 4'd12,
      B_QUEEN  = 4'd13,
      B_KING   = 4'd14
   } piece_t;

   typedef logic [5:0] square_t;       // Rank * 8 + file

   typedef piece_t [63:0] board_t;     // 256 bits, rank 0 on white's side

   function automatic logic [2:0] rank_of(square_t sq);
      return sq[5:3];
   endfunction

   function automatic logic is_black(piece_t p);
      return p[3];
   endfunction

endpackage

//--- hw/eval_pkg.sv
`include "eval_settings.svh"

package eval_pkg;

   // One middlegame / endgame pair, used for every partial score
   typedef struct packed
   {
      logic signed [`SUM_WIDTH-1:0] mg;
      logic signed [`SUM_WIDTH-1:0] eg;
   } score_t;

   // Controller sequence
   // S_IDLE       tracks board_in and waits for a board_valid edge
   // S_START      one-cycle start to the evaluators
   // S_WAIT_EVAL  collects the done pulses
   // S_WAIT_BLEND lets the blend pipeline drain
   // S_HOLD       result valid until clear_eval
   typedef enum logic [2:0]
   {
      S_IDLE       = 3'd0,
      S_START      = 3'd1,
      S_WAIT_EVAL  = 3'd2,
      S_WAIT_BLEND = 3'd3,
      S_HOLD       = 3'd4
   } ctrl_state_t;

endpackage

//--- hw/eval_control.sv
`timescale 1ns/1ps
`include "eval_settings.svh"

module eval_control
(
   input  logic                clk,
   input  logic                reset,
   input  logic                board_valid,
   input  chess_pkg::board_t   board_in,
   input  logic                clear_eval,
   input  logic                material_done,
   input  logic                pawn_done,
   output chess_pkg::board_t   board,
   output logic                start,
   output logic                eval_valid
);

   localparam int CNT_W = $clog2(`BLEND_LATENCY + 1);
   localparam logic [CNT_W-1:0] BLEND_LAST = CNT_W'(`BLEND_LATENCY - 1);

   eval_pkg::ctrl_state_t state;
   logic                  board_valid_r;     // For the rising edge
   logic                  material_seen;
   logic                  pawn_seen;
   logic [CNT_W-1:0]      blend_cnt;

   assign start      = (state == eval_pkg::S_START);
   assign eval_valid = (state == eval_pkg::S_HOLD);

   // Board follows the input while idle and is frozen afterwards
   always_ff @(posedge clk)
   begin
      if (state == eval_pkg::S_IDLE)
         board <= board_in;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= eval_pkg::S_IDLE;
         board_valid_r <= 1'b0;
         material_seen <= 1'b0;
         pawn_seen     <= 1'b0;
         blend_cnt     <= '0;
      end
      else
      begin
         board_valid_r <= board_valid;
         case (state)
            eval_pkg::S_IDLE:
            begin
               material_seen <= 1'b0;
               pawn_seen     <= 1'b0;
               blend_cnt     <= '0;
               if (board_valid && !board_valid_r)
                  state <= eval_pkg::S_START;
            end
            eval_pkg::S_START:
               state <= eval_pkg::S_WAIT_EVAL;
            eval_pkg::S_WAIT_EVAL:
            begin
               material_seen <= material_seen | material_done;   // Done pulses are one cycle
               pawn_seen     <= pawn_seen | pawn_done;
               if (material_seen && pawn_seen)
                  state <= eval_pkg::S_WAIT_BLEND;
            end
            eval_pkg::S_WAIT_BLEND:
            begin
               blend_cnt <= blend_cnt + 1'b1;
               if (blend_cnt == BLEND_LAST)
                  state <= eval_pkg::S_HOLD;
            end
            eval_pkg::S_HOLD:
               if (clear_eval)
                  state <= eval_pkg::S_IDLE;
            default:
               state <= eval_pkg::S_IDLE;
         endcase
      end
   end

endmodule

//--- hw/material_eval.sv
`timescale 1ns/1ps
`include "eval_settings.svh"

module material_eval
(
   input  logic                clk,
   input  logic                reset,
   input  logic                start,
   input  chess_pkg::board_t   board,
   output eval_pkg::score_t    score,
   output logic signed [31:0]  material,
   output logic                done
);

   localparam logic signed [`SUM_WIDTH-1:0] PAWN_MG   = 100;
   localparam logic signed [`SUM_WIDTH-1:0] PAWN_EG   = 120;
   localparam logic signed [`SUM_WIDTH-1:0] KNIGHT_MG = 320;
   localparam logic signed [`SUM_WIDTH-1:0] KNIGHT_EG = 300;
   localparam logic signed [`SUM_WIDTH-1:0] BISHOP_MG = 330;
   localparam logic signed [`SUM_WIDTH-1:0] BISHOP_EG = 320;
   localparam logic signed [`SUM_WIDTH-1:0] ROOK_MG   = 500;
   localparam logic signed [`SUM_WIDTH-1:0] ROOK_EG   = 520;
   localparam logic signed [`SUM_WIDTH-1:0] QUEEN_MG  = 900;
   localparam logic signed [`SUM_WIDTH-1:0] QUEEN_EG  = 950;

   eval_pkg::score_t rank_comb [8];
   eval_pkg::score_t rank_sum [8];    // Stage one
   eval_pkg::score_t total;
   logic             start_d;

   function automatic eval_pkg::score_t piece_value(chess_pkg::piece_t p);
      eval_pkg::score_t v;
      v = '0;                          // Kings and empty squares
      case (p)
         chess_pkg::W_PAWN,   chess_pkg::B_PAWN:   v = '{mg: PAWN_MG,   eg: PAWN_EG};
         chess_pkg::W_KNIGHT, chess_pkg::B_KNIGHT: v = '{mg: KNIGHT_MG, eg: KNIGHT_EG};
         chess_pkg::W_BISHOP, chess_pkg::B_BISHOP: v = '{mg: BISHOP_MG, eg: BISHOP_EG};
         chess_pkg::W_ROOK,   chess_pkg::B_ROOK:   v = '{mg: ROOK_MG,   eg: ROOK_EG};
         chess_pkg::W_QUEEN,  chess_pkg::B_QUEEN:  v = '{mg: QUEEN_MG,  eg: QUEEN_EG};
         default:                                  v = '0;
      endcase
      if (chess_pkg::is_black(p))
      begin
         v.mg = -v.mg;
         v.eg = -v.eg;
      end
      return v;
   endfunction

   always_comb
   begin
      eval_pkg::score_t   v;
      chess_pkg::square_t sq;
      for (int r = 0; r < 8; r++)
         rank_comb[r] = '0;
      for (int i = 0; i < 64; i++)
      begin
         sq = chess_pkg::square_t'(i);
         v  = piece_value(board[sq]);
         rank_comb[chess_pkg::rank_of(sq)].mg += v.mg;
         rank_comb[chess_pkg::rank_of(sq)].eg += v.eg;
      end
   end

   always_comb
   begin
      total = '0;
      for (int r = 0; r < 8; r++)
      begin
         total.mg += rank_sum[r].mg;
         total.eg += rank_sum[r].eg;
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
         rank_sum <= rank_comb;
      if (start_d)
      begin
         score    <= total;
         material <= 32'(total.mg);   // Sign extended
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         start_d <= 1'b0;
         done    <= 1'b0;
      end
      else
      begin
         start_d <= start;
         done    <= start_d;
      end
   end

endmodule

//--- hw/pawn_eval.sv
`timescale 1ns/1ps
`include "eval_settings.svh"

module pawn_eval
(
   input  logic                clk,
   input  logic                reset,
   input  logic                start,
   input  chess_pkg::board_t   board,
   output eval_pkg::score_t    score,
   output logic                done
);

   localparam logic signed [`SUM_WIDTH-1:0] MG_STEP  = 4;   // Per rank of advancement
   localparam logic signed [`SUM_WIDTH-1:0] EG_STEP  = 8;
   localparam logic signed [`SUM_WIDTH-1:0] STEP_ONE = 1;

   eval_pkg::score_t rank_comb [8];
   eval_pkg::score_t rank_sum [8];    // Stage one
   eval_pkg::score_t total;
   logic             start_d;

   function automatic eval_pkg::score_t pawn_bonus(chess_pkg::piece_t p, logic [2:0] rank);
      eval_pkg::score_t             v;
      logic [2:0]                   adv_rank;
      logic signed [`SUM_WIDTH-1:0] steps;
      v        = '0;
      adv_rank = chess_pkg::is_black(p) ? 3'd7 - rank : rank;   // Mirror for black
      steps    = $signed({{(`SUM_WIDTH - 3){1'b0}}, adv_rank}) - STEP_ONE;
      if (p == chess_pkg::W_PAWN)
      begin
         v.mg = steps * MG_STEP;
         v.eg = steps * EG_STEP;
      end
      else if (p == chess_pkg::B_PAWN)
      begin
         v.mg = -(steps * MG_STEP);
         v.eg = -(steps * EG_STEP);
      end
      return v;
   endfunction

   always_comb
   begin
      eval_pkg::score_t   v;
      chess_pkg::square_t sq;
      for (int r = 0; r < 8; r++)
         rank_comb[r] = '0;
      for (int i = 0; i < 64; i++)
      begin
         sq = chess_pkg::square_t'(i);
         v  = pawn_bonus(board[sq], chess_pkg::rank_of(sq));
         rank_comb[chess_pkg::rank_of(sq)].mg += v.mg;
         rank_comb[chess_pkg::rank_of(sq)].eg += v.eg;
      end
   end

   always_comb
   begin
      total = '0;
      for (int r = 0; r < 8; r++)
      begin
         total.mg += rank_sum[r].mg;
         total.eg += rank_sum[r].eg;
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
         rank_sum <= rank_comb;
      if (start_d)
         score <= total;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         start_d <= 1'b0;
         done    <= 1'b0;
      end
      else
      begin
         start_d <= start;
         done    <= start_d;
      end
   end

endmodule

//--- hw/phase_blend.sv
`timescale 1ns/1ps
`include "eval_settings.svh"

module phase_blend
(
   input  logic                           clk,
   input  chess_pkg::board_t              board,
   input  eval_pkg::score_t               material_score,
   input  eval_pkg::score_t               pawn_score,
   output logic signed [`EVAL_WIDTH-1:0]  eval
);

   localparam int PROD_W  = `SUM_WIDTH + 8;   // Sum times an 8-bit weight
   localparam int TOTAL_W = PROD_W + 1;
   localparam int SCALE_W = TOTAL_W + 17;

   localparam logic signed [7:0]         PHASE_CAP  = `PHASE_MAX;
   localparam logic signed [16:0]        RECIP      = `RECIP_62;
   localparam logic signed [SCALE_W-1:0] TRUNC_BIAS = (1 << `RECIP_SHIFT) - 1;

   logic [6:0]                occupied_cnt;   // 0 to 64
   logic signed [7:0]         phase;
   logic signed [7:0]         phase_s1;
   logic signed [7:0]         eg_weight_s1;
   eval_pkg::score_t          sum_s1;
   logic signed [PROD_W-1:0]  mg_prod_s2;
   logic signed [PROD_W-1:0]  eg_prod_s2;
   logic signed [TOTAL_W-1:0] total_s3;
   logic signed [SCALE_W-1:0] scaled_s4;
   logic signed [SCALE_W-1:0] bias;
   logic signed [SCALE_W-1:0] quotient;

   always_comb
   begin
      occupied_cnt = '0;
      for (int i = 0; i < 64; i++)
         occupied_cnt = occupied_cnt + 7'(board[i] != chess_pkg::EMPTY);
   end

   assign phase = (occupied_cnt > 7'(`PHASE_MAX)) ? PHASE_CAP : $signed({1'b0, occupied_cnt});

   // Negative scaled values round toward zero before the shift
   always_comb
   begin
      if (scaled_s4 < 0)
         bias = TRUNC_BIAS;
      else
         bias = '0;
   end

   assign quotient = (scaled_s4 + bias) >>> `RECIP_SHIFT;

   always_ff @(posedge clk)
   begin
      phase_s1     <= phase;                        // Stage 1
      eg_weight_s1 <= PHASE_CAP - phase;
      sum_s1.mg    <= material_score.mg + pawn_score.mg;
      sum_s1.eg    <= material_score.eg + pawn_score.eg;

      mg_prod_s2 <= sum_s1.mg * phase_s1;           // Stage 2
      eg_prod_s2 <= sum_s1.eg * eg_weight_s1;

      total_s3 <= mg_prod_s2 + eg_prod_s2;          // Stage 3

      scaled_s4 <= total_s3 * RECIP;                // Stage 4, times 2^20 / 62

      eval <= quotient[`EVAL_WIDTH-1:0];            // Stage 5
   end

endmodule

//--- hw/eval_top.sv
`timescale 1ns/1ps
`include "eval_settings.svh"

module eval_top
(
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           board_valid,
   input  chess_pkg::board_t              board_in,
   input  logic                           clear_eval,
   output logic signed [`EVAL_WIDTH-1:0]  eval,
   output logic                           eval_valid,
   output logic signed [31:0]             material
);

   chess_pkg::board_t board;           // Frozen copy for the evaluators
   logic              start;
   logic              material_done;
   logic              pawn_done;
   eval_pkg::score_t  material_score;
   eval_pkg::score_t  pawn_score;

   eval_control control0
   (
      .clk           (clk),
      .reset         (reset),
      .board_valid   (board_valid),
      .board_in      (board_in),
      .clear_eval    (clear_eval),
      .material_done (material_done),
      .pawn_done     (pawn_done),
      .board         (board),
      .start         (start),
      .eval_valid    (eval_valid)
   );

   material_eval material0
   (
      .clk      (clk),
      .reset    (reset),
      .start    (start),
      .board    (board),
      .score    (material_score),
      .material (material),
      .done     (material_done)
   );

   pawn_eval pawn0
   (
      .clk   (clk),
      .reset (reset),
      .start (start),
      .board (board),
      .score (pawn_score),
      .done  (pawn_done)
   );

   phase_blend blend0
   (
      .clk            (clk),
      .board          (board),
      .material_score (material_score),
      .pawn_score     (pawn_score),
      .eval           (eval)
   );

endmodule

//--- dv/eval_assert.sv
`timescale 1ns/1ps
`include "eval_settings.svh"

module eval_assert
(
   input logic                  clk,
   input logic                  reset,
   input eval_pkg::ctrl_state_t state,
   input logic                  start,
   input logic                  eval_valid,
   input logic                  clear_eval,
   input logic                  material_done,
   input logic                  pawn_done
);

   int fail_cnt = 0;                 // Failed assertions so far

   valid_low_after_reset: assert property (@(posedge clk) reset |=> !eval_valid)
      else
      begin
         $error("eval_valid high in the cycle after reset");
         fail_cnt++;
      end

   // Result stays up until the clear is seen
   valid_held: assert property (@(posedge clk) disable iff (reset)
      eval_valid && !clear_eval |=> eval_valid)
      else
      begin
         $error("eval_valid dropped without clear_eval");
         fail_cnt++;
      end

   material_done_timing: assert property (@(posedge clk) disable iff (reset)
      material_done |-> $past(start, `EVAL_LATENCY))
      else
      begin
         $error("material_done without a start EVAL_LATENCY cycles earlier");
         fail_cnt++;
      end

   pawn_done_timing: assert property (@(posedge clk) disable iff (reset)
      pawn_done |-> $past(start, `EVAL_LATENCY))
      else
      begin
         $error("pawn_done without a start EVAL_LATENCY cycles earlier");
         fail_cnt++;
      end

   state_legal: assert property (@(posedge clk) disable iff (reset)
      state inside {eval_pkg::S_IDLE, eval_pkg::S_START, eval_pkg::S_WAIT_EVAL,
                    eval_pkg::S_WAIT_BLEND, eval_pkg::S_HOLD})
      else
      begin
         $error("controller state outside the FSM encoding");
         fail_cnt++;
      end

endmodule

bind eval_control eval_assert assert0
(
   .clk           (clk),
   .reset         (reset),
   .state         (state),
   .start         (start),
   .eval_valid    (eval_valid),
   .clear_eval    (clear_eval),
   .material_done (material_done),
   .pawn_done     (pawn_done)
);

//--- dv/eval_tb.sv
`timescale 1ns/1ps
`include "eval_settings.svh"

module eval_tb;

   localparam int     NUM_TESTS   = 56;
   localparam longint WATCHDOG_NS = (NUM_TESTS * 40 + 200) * 40;

   // Piece values by kind, indexed by bits 2:0 of the piece code
   localparam int MG_VAL [8] = '{0, 100, 320, 330, 500, 900, 0, 0};
   localparam int EG_VAL [8] = '{0, 120, 300, 320, 520, 950, 0, 0};

   localparam chess_pkg::piece_t PIECES [12] = '{
      chess_pkg::W_PAWN, chess_pkg::W_KNIGHT, chess_pkg::W_BISHOP, chess_pkg::W_ROOK,
      chess_pkg::W_QUEEN, chess_pkg::W_KING, chess_pkg::B_PAWN, chess_pkg::B_KNIGHT,
      chess_pkg::B_BISHOP, chess_pkg::B_ROOK, chess_pkg::B_QUEEN, chess_pkg::B_KING};

   localparam chess_pkg::piece_t BACK_RANK [8] = '{
      chess_pkg::W_ROOK, chess_pkg::W_KNIGHT, chess_pkg::W_BISHOP, chess_pkg::W_QUEEN,
      chess_pkg::W_KING, chess_pkg::W_BISHOP, chess_pkg::W_KNIGHT, chess_pkg::W_ROOK};

   typedef struct packed
   {
      logic signed [`EVAL_WIDTH-1:0] eval;
      logic signed [31:0]            material;
   } result_t;

   logic                          clk;
   logic                          reset;
   logic                          board_valid;
   chess_pkg::board_t             board_in;
   logic                          clear_eval;
   logic signed [`EVAL_WIDTH-1:0] eval;
   logic                          eval_valid;
   logic signed [31:0]            material;

   result_t exp_q [$];               // Expected results in launch order
   string   name_q [$];
   int      issued;
   int      checked;
   int      failed_tests;
   int      error_cnt;
   int      hold_cycles;             // Extra cycles before clear_eval

   eval_top dut0
   (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .board_in    (board_in),
      .clear_eval  (clear_eval),
      .eval        (eval),
      .eval_valid  (eval_valid),
      .material    (material)
   );

   always #20 clk = ~clk;

   function automatic result_t ref_eval(chess_pkg::board_t b);
      longint  mat_mg;
      longint  mat_eg;
      longint  pawn_mg;
      longint  pawn_eg;
      longint  phase;
      longint  recip;
      longint  blended;
      int      kind;
      int      sign;
      int      adv;
      result_t res;
      mat_mg  = 0;
      mat_eg  = 0;
      pawn_mg = 0;
      pawn_eg = 0;
      phase   = 0;
      for (int i = 0; i < 64; i++)
      begin
         kind = int'(b[i][2:0]);
         sign = b[i][3] ? -1 : 1;
         if (b[i] != chess_pkg::EMPTY)
            phase++;
         mat_mg += sign * MG_VAL[kind];
         mat_eg += sign * EG_VAL[kind];
         if (kind == 1)
         begin
            adv = b[i][3] ? 7 - i / 8 : i / 8;   // Rank seen from the pawn's own side
            pawn_mg += sign * 4 * (adv - 1);
            pawn_eg += sign * 8 * (adv - 1);
         end
      end
      if (phase > `PHASE_MAX)
         phase = `PHASE_MAX;
      recip   = (64'sd1 << `RECIP_SHIFT) / `PHASE_MAX;
      blended = ((mat_mg + pawn_mg) * phase + (mat_eg + pawn_eg) * (`PHASE_MAX - phase)) * recip;
      blended = blended / (64'sd1 << `RECIP_SHIFT);   // Signed divide truncates toward zero
      res.eval     = blended[`EVAL_WIDTH-1:0];
      res.material = mat_mg[31:0];
      return res;
   endfunction

   function automatic chess_pkg::board_t empty_board();
      chess_pkg::board_t b;
      for (int i = 0; i < 64; i++)
         b[i] = chess_pkg::EMPTY;
      return b;
   endfunction

   function automatic chess_pkg::board_t start_position();
      chess_pkg::board_t b;
      b = empty_board();
      for (int f = 0; f < 8; f++)
      begin
         b[f]      = BACK_RANK[f];
         b[8 + f]  = chess_pkg::W_PAWN;
         b[48 + f] = chess_pkg::B_PAWN;
         b[56 + f] = chess_pkg::piece_t'(BACK_RANK[f] + 4'd8);   // Same kind, black
      end
      return b;
   endfunction

   // All 64 squares occupied, white well ahead
   function automatic chess_pkg::board_t full_board();
      chess_pkg::board_t b;
      b = start_position();
      for (int f = 0; f < 8; f++)
      begin
         b[16 + f] = chess_pkg::W_QUEEN;
         b[24 + f] = chess_pkg::W_PAWN;
         b[32 + f] = chess_pkg::B_PAWN;
         b[40 + f] = chess_pkg::B_KNIGHT;
      end
      return b;
   endfunction

   function automatic chess_pkg::board_t random_board();
      chess_pkg::board_t b;
      for (int i = 0; i < 64; i++)
      begin
         if ($urandom % 2)
            b[i] = chess_pkg::EMPTY;
         else
            b[i] = PIECES[$urandom % 12];
      end
      for (int r = 0; r < 8; r++)   // At least one pawn on every rank
         b[r * 8 + $urandom % 8] = ($urandom % 2) ? chess_pkg::W_PAWN : chess_pkg::B_PAWN;
      return b;
   endfunction

   task automatic launch_board(chess_pkg::board_t b, string name);
      exp_q.push_back(ref_eval(b));
      name_q.push_back(name);
      issued++;
      @(posedge clk);
      #2;
      board_in    = b;
      board_valid = 1'b0;
      @(posedge clk);
      #2;
      board_valid = 1'b1;                      // Rising edge starts the evaluation
      @(posedge clk);
      #2;
      board_valid = 1'b0;
   endtask

   task automatic apply_board(chess_pkg::board_t b, string name);
      launch_board(b, name);
      wait (checked == issued);
   endtask

   initial
   begin
      chess_pkg::board_t b;
      void'($urandom(32'h3197d29b));
      clk          = 1'b0;
      reset        = 1'b1;
      board_valid  = 1'b0;
      board_in     = empty_board();
      clear_eval   = 1'b0;
      issued       = 0;
      checked      = 0;
      failed_tests = 0;
      error_cnt    = 0;
      hold_cycles  = 0;
      repeat (10) @(posedge clk);
      #2;
      reset = 1'b0;

      apply_board(empty_board(), "empty");
      apply_board(start_position(), "start_pos");
      b     = empty_board();
      b[4]  = chess_pkg::W_KING;
      b[60] = chess_pkg::B_KING;
      b[3]  = chess_pkg::W_QUEEN;
      apply_board(b, "kings_queen");
      for (int n = 0; n < 50; n++)
         apply_board(random_board(), $sformatf("random_%0d", n));
      apply_board(full_board(), "full_board");

      // Result must survive a late clear and a stray board_valid edge
      hold_cycles = 20;
      launch_board(random_board(), "hold");
      do
         @(negedge clk);
      while (!eval_valid);
      @(posedge clk);
      #2;
      board_in    = start_position();
      board_valid = 1'b1;
      repeat (2) @(posedge clk);
      #2;
      board_valid = 1'b0;
      wait (checked == issued);
      hold_cycles = 0;
      apply_board(random_board(), "after_hold");

      $display("Tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
               checked, failed_tests, error_cnt, dut0.control0.assert0.fail_cnt);
      if (failed_tests == 0 && error_cnt == 0 && dut0.control0.assert0.fail_cnt == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

   // Compare process, samples on the falling edge
   initial
   begin
      result_t exp;
      string   name;
      logic    ok;
      logic    have_exp;
      forever
      begin
         @(negedge clk);
         if (eval_valid)
         begin
            have_exp = (exp_q.size() != 0);
            if (have_exp)
            begin
               exp  = exp_q.pop_front();
               name = name_q.pop_front();
               ok   = 1'b1;
               if (eval !== exp.eval)
               begin
                  $display("ERR eval expected %h actual %h in %s", exp.eval, eval, name);
                  ok = 1'b0;
                  error_cnt++;
               end
               if (material !== exp.material)
               begin
                  $display("ERR material expected %h actual %h in %s",
                           exp.material, material, name);
                  ok = 1'b0;
                  error_cnt++;
               end
               for (int c = 0; c < hold_cycles; c++)
               begin
                  @(negedge clk);
                  if (!eval_valid)
                  begin
                     $display("eval_valid dropped before clear_eval in %s", name);
                     ok = 1'b0;
                     error_cnt++;
                  end
                  if (eval !== exp.eval)
                  begin
                     $display("ERR eval expected %h actual %h while held in %s",
                              exp.eval, eval, name);
                     ok = 1'b0;
                     error_cnt++;
                  end
               end
            end
            else
            begin
               $display("eval_valid went high with no board pending");
               error_cnt++;
            end
            @(posedge clk);
            #2;
            clear_eval = 1'b1;
            @(posedge clk);
            #2;
            clear_eval = 1'b0;
            if (have_exp)
            begin
               $display("test %s eval %0d material %0d %s", name, exp.eval,
                        exp.material, ok ? "ok" : "mismatch");
               if (!ok)
                  failed_tests++;
               checked++;
            end
         end
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog timeout, only %0d of %0d tests finished", checked, NUM_TESTS);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

//--- all.f
+incdir+hw
hw/chess_pkg.sv
hw/eval_pkg.sv
hw/eval_control.sv
hw/material_eval.sv
hw/pawn_eval.sv
hw/phase_blend.sv
hw/eval_top.sv
dv/eval_assert.sv
dv/eval_tb.sv
